//--- mult_pkg.sv
// fixed 32x32 signed widths only, no unsigned mode and no parameters to resize
package mult_pkg;

  // signed operand, used for both the multiplicand and the multiplier
  typedef logic signed [31:0] word_t;

  // signed full product
  typedef logic signed [63:0] prod_t;

  // shift counter, bit 5 sets once 32 shifts are done
  typedef logic [5:0] count_t;

  // one step command from the sequencer to the datapath
  typedef struct packed {
    logic add0;    // 1 adds zero into the upper half
    logic do_sub;  // 1 subtracts the multiplicand
    logic a_s;     // 0 add phase, 1 shift phase
    logic step_en; // datapath updates at the next edge
  } booth_op_t;

  // sequencer states
  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_add   = 2'd1,
    st_shift = 2'd2,
    st_done  = 2'd3
  } ctrl_state_t;

endpackage

//--- mult_control.sv
// do_mult restarts at any time, latency is fixed at 32 add/shift pairs plus a staggered done
`timescale 1ns/1ps

module mult_control (
  input  logic              m_clk,
  input  logic              reset,     // sync, active high
  input  logic              do_mult,   // start pulse, also aborts a running multiply
  input  logic              prod_lsb,  // current multiplier bit from the datapath
  output mult_pkg::booth_op_t op,      // step command, combinational
  output logic              mult_done  // one-cycle pulse after the 32nd shift
);

  import mult_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_next;
  count_t      count;      // number of shifts done so far
  count_t      count_next;
  logic        prev_lsb;   // multiplier bit seen on the previous step, 0 before the first

  assign count_next = count + count_t'(1);

  // next state, add and shift alternate until the counter reaches 32
  always_comb begin
    state_next = state;
    case (state)
      st_idle:  state_next = st_idle;  // waits for do_mult
      st_add:   state_next = st_shift;
      st_shift: state_next = count_next[5] ? st_done : st_add;
      st_done:  state_next = st_idle;  // one cycle only
      default:  state_next = st_idle;
    endcase
  end

  always_ff @(posedge m_clk) begin
    if (reset) begin
      state <= st_idle;
    end else if (do_mult) begin
      state <= st_add;  // restart wins over whatever is running
    end else begin
      state <= state_next;
    end
  end

  // counter and previous bit are cleared together by reset or a start
  always_ff @(posedge m_clk) begin
    if (reset || do_mult) begin
      count    <= '0;
      prev_lsb <= 1'b0;
    end else if (state == st_shift) begin
      count    <= count_next;  // counts shift edges
      prev_lsb <= prod_lsb;    // bit about to leave becomes the previous bit
    end
  end

  // staggered done, registered one cycle after the done state
  always_ff @(posedge m_clk) begin
    if (reset || do_mult) begin
      mult_done <= 1'b0;
    end else begin
      mult_done <= (state == st_done);
    end
  end

  // step decode
  // equal bits add zero, 1 after 0 subtracts, 0 after 1 adds
  always_comb begin
    op.add0    = 1'b0;
    op.do_sub  = 1'b0;
    op.a_s     = (state == st_shift);
    op.step_en = ((state == st_add) || (state == st_shift)) && !do_mult; // load takes priority
    if (state == st_add) begin
      op.add0   = (prod_lsb == prev_lsb);
      op.do_sub = prod_lsb && !prev_lsb;
    end
  end

  // done must be a single cycle even across back-to-back multiplies
  a_done_single : assert property (@(posedge m_clk) disable iff (reset)
    mult_done |=> !mult_done);

  // the two add modifiers are exclusive
  a_op_exclusive : assert property (@(posedge m_clk) disable iff (reset)
    !(op.add0 && op.do_sub));

endmodule

//--- booth_datapath.sv
// working register has no reset and is only meaningful after a do_mult load
`timescale 1ns/1ps

module booth_datapath (
  input  logic                m_clk,
  input  logic                reset,        // only disables the check below
  input  logic                do_mult,      // loads operands
  input  mult_pkg::word_t     a,            // multiplicand
  input  mult_pkg::word_t     b,            // multiplier
  input  mult_pkg::booth_op_t op,           // step command from control
  output logic                prod_lsb,     // multiplier bit under test
  output mult_pkg::prod_t     work_product  // upper and multiplier halves
);

  import mult_pkg::*;

  word_t       mcand;      // multiplicand held for the whole multiply
  logic [64:0] work;       // {upper half, multiplier half, appended bit}
  logic        guard;      // sign bit of the 33-bit upper value
  logic [32:0] upper_ext;  // upper half with its guard sign
  logic [32:0] addend;
  logic [32:0] sum;

  assign upper_ext = {guard, work[64:33]};
  assign addend    = op.add0 ? 33'd0 : {mcand[31], mcand}; // sign extended
  assign sum       = op.do_sub ? (upper_ext - addend) : (upper_ext + addend);

  always_ff @(posedge m_clk) begin
    if (do_mult) begin
      mcand <= a;
      work  <= {32'd0, b, 1'b0};
      guard <= 1'b0;
    end else if (op.step_en) begin
      if (op.a_s) begin
        // arithmetic shift of the whole 66-bit value, guard keeps its sign
        work <= {guard, work[64:1]};
      end else begin
        work[64:33] <= sum[31:0];
        guard       <= sum[32]; // keeps the true sign when -2^31 is subtracted
      end
    end
  end

  assign prod_lsb     = work[1];  // low bit of the multiplier half
  assign work_product = prod_t'(work[64:1]);

  // a step never lands on a load edge, and every shift follows an add
  a_step_order : assert property (@(posedge m_clk) disable iff (reset)
    op.step_en |-> !do_mult && (!op.a_s || $past(op.step_en && !op.a_s)));

endmodule

//--- product_buffer.sv
// holds the last finished product, valid drops as soon as a new start is seen
`timescale 1ns/1ps

module product_buffer (
  input  logic            m_clk,
  input  logic            reset,         // sync, active high
  input  logic            do_mult,       // new start invalidates the held result
  input  logic            mult_done,     // capture strobe
  input  mult_pkg::prod_t work_product,  // finished value from the datapath
  output mult_pkg::prod_t product,
  output logic            product_valid
);

  always_ff @(posedge m_clk) begin
    if (reset) begin
      product       <= '0;
      product_valid <= 1'b0;
    end else if (do_mult) begin
      product_valid <= 1'b0;  // keep old value but mark it stale
    end else if (mult_done) begin
      product       <= work_product;
      product_valid <= 1'b1;
    end
  end

  // held value is frozen while it is reported valid
  a_product_hold : assert property (@(posedge m_clk) disable iff (reset)
    product_valid |=> !product_valid || $stable(product));

endmodule

//--- mult_unit.sv
// single clock m_clk only, do_mult must be a one-cycle pulse and restarts any multiply
`timescale 1ns/1ps

module mult_unit (
  input  logic            m_clk,
  input  logic            reset,         // sync, active high
  input  logic            do_mult,       // start pulse
  input  mult_pkg::word_t a,             // sampled with do_mult
  input  mult_pkg::word_t b,             // sampled with do_mult
  output mult_pkg::prod_t product,       // held result
  output logic            mult_done,     // one-cycle pulse, 65 edges after the start
  output logic            product_valid  // level, 66 edges after the start
);

  import mult_pkg::*;

  booth_op_t op;           // step command
  logic      prod_lsb;     // multiplier bit back to the sequencer
  prod_t     work_product; // running product

  mult_control u_control (
    .m_clk     (m_clk),
    .reset     (reset),
    .do_mult   (do_mult),
    .prod_lsb  (prod_lsb),
    .op        (op),
    .mult_done (mult_done)
  );

  booth_datapath u_datapath (
    .m_clk        (m_clk),
    .reset        (reset),
    .do_mult      (do_mult),
    .a            (a),
    .b            (b),
    .op           (op),
    .prod_lsb     (prod_lsb),
    .work_product (work_product)
  );

  product_buffer u_buffer (
    .m_clk         (m_clk),
    .reset         (reset),
    .do_mult       (do_mult),
    .mult_done     (mult_done),
    .work_product  (work_product),
    .product       (product),
    .product_valid (product_valid)
  );

endmodule

//--- tb_mult_unit.sv
// expects mult_vectors.txt in the run directory, checks are sampled on the falling edge
`timescale 1ns/1ps

module tb_mult_unit;

  import mult_pkg::*;

  localparam int MAX_VECS        = 64;  // room in the vector memory
  localparam int REC_WORDS       = 5;   // name, a, b, expected, restart
  localparam int DONE_EDGE       = 65;  // mult_done high in the cycle after this edge
  localparam int DONE_LIMIT      = 100; // give up on a missing mult_done
  localparam int RESTART_GAP     = 20;  // edges between the first and second start
  localparam int HOLD_CYCLES     = 3;   // idle cycles with the result held
  localparam int CYCLES_PER_VEC  = 80;
  localparam int WATCHDOG_MARGIN = 200;

  logic  m_clk;
  logic  reset;
  logic  do_mult;
  word_t a;
  word_t b;
  prod_t product;
  logic  mult_done;
  logic  product_valid;

  logic [63:0] vec_mem [0:MAX_VECS*REC_WORDS-1]; // flat records of five words
  int num_vecs;
  int error_count;   // all mismatches of the run
  int test_errors;   // mismatches of the running test
  int pass_count;
  int fail_count;
  bit vecs_loaded;

  mult_unit UUT (
    .m_clk         (m_clk),
    .reset         (reset),
    .do_mult       (do_mult),
    .a             (a),
    .b             (b),
    .product       (product),
    .mult_done     (mult_done),
    .product_valid (product_valid)
  );

  initial m_clk = 1'b0;
  always #50 m_clk = ~m_clk; // 100 ns period

  function automatic string test_name(input logic [7:0] idx);
    case (idx)
      8'h01:   return "pos_pos_small";
      8'h02:   return "pos_pos_wide";
      8'h03:   return "neg_pos";
      8'h04:   return "pos_neg";
      8'h05:   return "neg_neg_ones";
      8'h06:   return "neg_neg_small";
      8'h07:   return "zero_a";
      8'h08:   return "zero_b";
      8'h09:   return "min_min";
      8'h0a:   return "min_one";
      8'h0b:   return "min_neg_one";
      8'h0c:   return "max_max";
      8'h0d:   return "max_min";
      8'h0e:   return "alt_55_pos";
      8'h0f:   return "alt_aa_pos";
      8'h10:   return "alt_aa_neg";
      8'h11:   return "shift_by_16";
      8'h12:   return "restart_mixed";
      8'h13:   return "restart_extreme";
      8'h14:   return "neg_wide";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_value(input string test, input string what,
                             input logic [63:0] expected, input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Error %s %s: expected %h, actual %h", test, what, expected, actual);
      error_count++;
      test_errors++;
    end
  endtask

  // returns at the edge that samples do_mult
  task automatic start_mult(input word_t mcand_in, input word_t mplier_in);
    @(posedge m_clk);
    do_mult <= 1'b1;
    a       <= mcand_in;
    b       <= mplier_in;
    @(posedge m_clk);
    do_mult <= 1'b0;
  endtask

  task automatic run_vector(input int vec_idx);
    int    base;
    int    edges;
    string name;
    word_t op_a;
    word_t op_b;
    prod_t expected;
    logic  restart;
    logic  got_done;
    base     = vec_idx * REC_WORDS;
    name     = test_name(vec_mem[base][7:0]);
    op_a     = vec_mem[base+1][31:0];
    op_b     = vec_mem[base+2][31:0];
    expected = vec_mem[base+3];
    restart  = (vec_mem[base+4] != 64'd0);
    test_errors = 0;
    if (restart) begin
      start_mult(~op_a, ~op_b); // first multiply is abandoned midway
      repeat (RESTART_GAP - 1) begin // second start sampled RESTART_GAP edges later
        @(negedge m_clk);
        check_value(name, "mult_done before restart", 64'd0, 64'(mult_done));
      end
    end
    start_mult(op_a, op_b);
    edges    = 0; // edges after the start edge
    got_done = 1'b0;
    while (!got_done && edges < DONE_LIMIT) begin
      @(negedge m_clk); // in the cycle that follows edge number edges
      if (edges == 0)
        check_value(name, "valid after start", 64'd0, 64'(product_valid)); // dropped at start
      got_done = mult_done;
      if (!got_done)
        edges++;
    end
    if (!got_done) begin
      $display("%s: mult_done did not arrive within %0d cycles of the start", name, DONE_LIMIT);
      error_count++;
      test_errors++;
    end else begin
      check_value(name, "done edge", 64'(DONE_EDGE), 64'(edges)); // low on all earlier edges
      @(negedge m_clk);
      check_value(name, "mult_done width", 64'd0, 64'(mult_done));
      check_value(name, "product_valid", 64'd1, 64'(product_valid));
      check_value(name, "product", expected, product);
      repeat (HOLD_CYCLES) begin // result must sit still while idle
        @(negedge m_clk);
        check_value(name, "held product", expected, product);
        check_value(name, "held valid", 64'd1, 64'(product_valid));
        check_value(name, "idle mult_done", 64'd0, 64'(mult_done));
      end
    end
    if (test_errors == 0) begin
      $display("test %s ok", name);
      pass_count++;
    end else begin
      $display("test %s failed with %0d mismatches", name, test_errors);
      fail_count++;
    end
  endtask

  // watchdog sized from the number of vectors
  initial begin
    wait (vecs_loaded);
    repeat (num_vecs * CYCLES_PER_VEC + WATCHDOG_MARGIN) @(posedge m_clk);
    $display("run timed out waiting for mult_done");
    $display("sim failed");
    $finish;
  end

  initial begin
    int i;
    reset   <= 1'b1;
    do_mult <= 1'b0;
    a       <= '0;
    b       <= '0;
    error_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    $readmemh("mult_vectors.txt", vec_mem);
    num_vecs = 0;
    while (num_vecs < MAX_VECS && vec_mem[num_vecs*REC_WORDS] !== 64'hff)
      num_vecs++; // ff in the name column ends the list
    vecs_loaded = 1'b1;
    repeat (2) @(posedge m_clk);
    reset <= 1'b0;
    // outputs right after reset, before any start
    test_errors = 0;
    @(negedge m_clk);
    check_value("reset_state", "product_valid", 64'd0, 64'(product_valid));
    check_value("reset_state", "mult_done", 64'd0, 64'(mult_done));
    check_value("reset_state", "product", 64'd0, product);
    if (test_errors == 0) begin
      $display("test reset_state ok");
      pass_count++;
    end else begin
      $display("test reset_state failed with %0d mismatches", test_errors);
      fail_count++;
    end
    if (num_vecs == 0) begin
      $display("no test vectors found in mult_vectors.txt");
      error_count++;
    end
    for (i = 0; i < num_vecs; i++)
      run_vector(i);
    $display("%0d tests, %0d ok, %0d failed, %0d mismatches",
             pass_count + fail_count, pass_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- mult_vectors.txt
// name   a        b        expected product (signed 64-bit a*b)  restart
// restart 1 first starts with ~a and ~b, then restarts with a and b
01 00000007 00000006 000000000000002a 0
02 00010000 00010000 0000000100000000 0
03 fffffffd 00000005 fffffffffffffff1 0
04 00000100 fffffffe fffffffffffffe00 0
05 ffffffff ffffffff 0000000000000001 0
06 fffffffc fffffffb 0000000000000014 0
07 00000000 12345678 0000000000000000 0
08 7fffffff 00000000 0000000000000000 0
09 80000000 80000000 4000000000000000 0
0a 80000000 00000001 ffffffff80000000 0
0b 80000000 ffffffff 0000000080000000 0
0c 7fffffff 7fffffff 3fffffff00000001 0
0d 7fffffff 80000000 c000000080000000 0
0e 00000003 55555555 00000000ffffffff 0
0f 00000005 aaaaaaaa fffffffe55555552 0
10 ffffffff aaaaaaaa 0000000055555556 0
11 12345678 00000010 0000000123456780 0
12 00000009 fffffff9 ffffffffffffffc1 1
13 80000000 7fffffff c000000080000000 1
14 ffff0000 00010000 ffffffff00000000 0
// end of list
ff 00000000 00000000 0000000000000000 0

//--- build.f
mult_pkg.sv
mult_control.sv
booth_datapath.sv
product_buffer.sv
mult_unit.sv
tb_mult_unit.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mult_unit
FILELIST  = build.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
